/* include/errt_settings.svh */
`ifndef ERRT_SETTINGS_SVH
`define ERRT_SETTINGS_SVH

// Number of receiver lanes sampled per trigger.
`define ERRT_LANES 48
// Width of one signed equalizer error.
`define ERRT_ERR_BITS 8

// Capture memory depth is 2**ERRT_ADDR_BITS words, four per capture.
`define ERRT_ADDR_BITS 6

// Window of sliding-detector flags kept in the flag frame.
`define ERRT_SD_FIRST 8
`define ERRT_SD_COUNT 24

// One memory word and the number of 32-bit chunks it is read back in.
`define ERRT_FRAME_BITS 144
`define ERRT_CHUNKS 5

`endif

/* rtl/errt_frame_pkg.sv */
`include "errt_settings.svh"

package errt_frame_pkg;

	// Error bytes in one error frame, one third of the lanes.
	localparam int ERR_PER_FRAME = `ERRT_LANES / 3;
	localparam int PAD_BITS = `ERRT_FRAME_BITS - ERR_PER_FRAME * `ERRT_ERR_BITS;

	typedef logic signed [`ERRT_ERR_BITS-1:0] err_t;

	// One sample of every lane, taken in the same cycle.
	typedef struct packed {
		err_t [`ERRT_LANES-1:0] err;
		logic [`ERRT_LANES-1:0] prbs;
		logic [`ERRT_LANES-1:0] data;
		logic [`ERRT_LANES-1:0][1:0] sd;
	} lane_sample_t;

	// Error frame. Lane errors sit from bit 0 up, the top 16 bits are zero.
	typedef struct packed {
		logic [PAD_BITS-1:0] pad;
		err_t [ERR_PER_FRAME-1:0] err;
	} err_frame_t;

	// Flag frame: PRBS flags low, data bits above them, detector window on top.
	typedef struct packed {
		logic [`ERRT_SD_COUNT-1:0][1:0] sd;
		logic [`ERRT_LANES-1:0] data;
		logic [`ERRT_LANES-1:0] prbs;
	} flag_frame_t;

	// A stored word is read as an error frame for indexes 0 to 2
	// and as the flag frame for index 3.
	typedef union packed {
		err_frame_t err;
		flag_frame_t flag;
		logic [`ERRT_FRAME_BITS-1:0] raw;
	} capture_word_u;

endpackage

/* rtl/errt_ctrl_pkg.sv */
`include "errt_settings.svh"

package errt_ctrl_pkg;

	localparam int CHUNK_BITS = $clog2(`ERRT_CHUNKS);
	localparam int DBG_DATA_BITS = 32;
	// Fill counts up to the full depth, so it needs one bit more than the address.
	localparam int FILL_BITS = `ERRT_ADDR_BITS + 1;

	// Request levels and pulses from the debug side.
	typedef struct packed {
		logic [`ERRT_ADDR_BITS-1:0] addr;
		logic [CHUNK_BITS-1:0] chunk;
		logic read;
		logic enable;
	} dbg_req_t;

	// Readback data and capture status.
	typedef struct packed {
		logic [DBG_DATA_BITS-1:0] data;
		logic frozen;
		logic [FILL_BITS-1:0] fill;
	} dbg_rsp_t;

	typedef enum logic [1:0] {
		READY = 2'd0,
		STORE = 2'd1,
		DONE = 2'd2
	} capture_state_t;

endpackage

/* rtl/frame_packer.sv */
`include "errt_settings.svh"

module frame_packer (
	input logic clk,
	input logic rstb,
	input logic snap,
	input errt_frame_pkg::lane_sample_t lanes,
	input logic [1:0] frame_idx,
	output errt_frame_pkg::capture_word_u frame
);

	import errt_frame_pkg::*;

	lane_sample_t sample;
	err_frame_t err_frame;
	flag_frame_t flag_frame;

	// Hold the sample for the four cycles it takes to store it.
	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			sample <= '0;
		end else if (snap) begin
			sample <= lanes;
		end
	end

	// Error frame for the lane group named by frame_idx.
	always_comb begin
		err_frame.pad = '0;
		for (int i = 0; i < ERR_PER_FRAME; i++) begin
			err_frame.err[i] = sample.err[ERR_PER_FRAME * frame_idx + i];
		end
	end

	always_comb begin
		flag_frame.prbs = sample.prbs;
		flag_frame.data = sample.data;
		// Only the detector window is kept.
		for (int i = 0; i < `ERRT_SD_COUNT; i++) begin
			flag_frame.sd[i] = sample.sd[`ERRT_SD_FIRST + i];
		end
	end

	// The last frame of a capture carries the flags.
	always_comb begin
		if (frame_idx == 2'd3) begin
			frame.flag = flag_frame;
		end else begin
			frame.err = err_frame;
		end
	end

endmodule

/* rtl/error_tracker.sv */
`include "errt_settings.svh"

module error_tracker (
	input logic clk,
	input logic rstb,
	input logic trigger,
	input logic read,
	input logic enable,
	input logic [`ERRT_ADDR_BITS-1:0] read_addr,
	input errt_frame_pkg::capture_word_u frame,
	output logic snap,
	output logic [1:0] frame_idx,
	output logic mem_we,
	output logic [`ERRT_ADDR_BITS-1:0] mem_addr,
	output logic [`ERRT_FRAME_BITS-1:0] mem_wdata,
	output logic frozen,
	output logic [errt_ctrl_pkg::FILL_BITS-1:0] fill
);

	import errt_ctrl_pkg::*;

	capture_state_t state;
	logic [1:0] frame_cnt;
	logic [`ERRT_ADDR_BITS-1:0] wr_ptr;
	logic last_addr;
	logic last_frame;

	// The write pointer is the low part of the fill count.
	assign wr_ptr = fill[`ERRT_ADDR_BITS-1:0];
	assign last_addr = (wr_ptr == {`ERRT_ADDR_BITS{1'b1}});
	assign last_frame = (frame_cnt == 2'd3);

	// A trigger only counts while idle, so one in STORE is dropped.
	assign snap = (state == READY) && trigger;
	assign frame_idx = frame_cnt;

	// One frame is written on every STORE cycle.
	assign mem_we = (state == STORE);
	assign mem_wdata = frame.raw;

	// Once frozen, the memory port belongs to the debug side.
	assign mem_addr = (state == DONE) ? read_addr : wr_ptr;
	assign frozen = (state == DONE);

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			state <= READY;
			frame_cnt <= '0;
			fill <= '0;
		end else begin
			case (state)
				READY: begin
					if (trigger) begin
						state <= STORE;
					end else if (read) begin
						state <= DONE;
					end
				end
				STORE: begin
					fill <= fill + 1'b1;
					frame_cnt <= frame_cnt + 1'b1;
					// Full memory wins over the end of the capture.
					if (last_addr) begin
						state <= DONE;
					end else if (last_frame) begin
						state <= read ? DONE : READY;
					end
				end
				DONE: begin
					if (enable) begin
						fill <= '0;
						frame_cnt <= '0;
						state <= READY;
					end
				end
				default: begin
					state <= READY;
				end
			endcase
		end
	end

endmodule

/* rtl/capture_sram.sv */
`include "errt_settings.svh"

module capture_sram (
	input logic clk,
	input logic we,
	input logic [`ERRT_ADDR_BITS-1:0] addr,
	input logic [`ERRT_FRAME_BITS-1:0] wdata,
	output logic [`ERRT_FRAME_BITS-1:0] rdata
);

	localparam int DEPTH = 1 << `ERRT_ADDR_BITS;

	logic [`ERRT_FRAME_BITS-1:0] mem [DEPTH];

	// Single port. A write also shows up on the read output.
	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
			rdata <= wdata;
		end else begin
			rdata <= mem[addr];
		end
	end

endmodule

/* rtl/debug_readout.sv */
`include "errt_settings.svh"

module debug_readout (
	input logic clk,
	input logic rstb,
	input logic [errt_ctrl_pkg::CHUNK_BITS-1:0] chunk,
	input logic [`ERRT_FRAME_BITS-1:0] word,
	output logic [errt_ctrl_pkg::DBG_DATA_BITS-1:0] data
);

	import errt_ctrl_pkg::*;

	localparam int TAIL_BITS = `ERRT_FRAME_BITS - (`ERRT_CHUNKS - 1) * DBG_DATA_BITS;

	logic [CHUNK_BITS-1:0] chunk_q;

	// Delay the index by one cycle so it meets the registered read word.
	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			chunk_q <= '0;
		end else begin
			chunk_q <= chunk;
		end
	end

	always_comb begin
		if (chunk_q < CHUNK_BITS'(`ERRT_CHUNKS - 1)) begin
			data = word[DBG_DATA_BITS * chunk_q +: DBG_DATA_BITS];
		end else if (chunk_q == CHUNK_BITS'(`ERRT_CHUNKS - 1)) begin
			// Short last chunk, left aligned.
			data = {word[`ERRT_FRAME_BITS-1 -: TAIL_BITS], {(DBG_DATA_BITS - TAIL_BITS){1'b0}}};
		end else begin
			data = '0;
		end
	end

endmodule

/* rtl/errt_top.sv */
`include "errt_settings.svh"

module errt_top (
	input logic clk,
	input logic rstb,
	input logic trigger,
	input errt_frame_pkg::lane_sample_t lanes,
	input errt_ctrl_pkg::dbg_req_t dbg,
	output errt_ctrl_pkg::dbg_rsp_t rsp
);

	import errt_frame_pkg::*;

	logic snap;
	logic [1:0] frame_idx;
	capture_word_u frame;

	logic mem_we;
	logic [`ERRT_ADDR_BITS-1:0] mem_addr;
	logic [`ERRT_FRAME_BITS-1:0] mem_wdata;
	logic [`ERRT_FRAME_BITS-1:0] mem_rdata;

	frame_packer packer0 (
		.clk(clk),
		.rstb(rstb),
		.snap(snap),
		.lanes(lanes),
		.frame_idx(frame_idx),
		.frame(frame)
	);

	error_tracker tracker0 (
		.clk(clk),
		.rstb(rstb),
		.trigger(trigger),
		.read(dbg.read),
		.enable(dbg.enable),
		.read_addr(dbg.addr),
		.frame(frame),
		.snap(snap),
		.frame_idx(frame_idx),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.frozen(rsp.frozen),
		.fill(rsp.fill)
	);

	capture_sram sram0 (
		.clk(clk),
		.we(mem_we),
		.addr(mem_addr),
		.wdata(mem_wdata),
		.rdata(mem_rdata)
	);

	// Chunk select goes straight to the readout, timed against the memory read.
	debug_readout readout0 (
		.clk(clk),
		.rstb(rstb),
		.chunk(dbg.chunk),
		.word(mem_rdata),
		.data(rsp.data)
	);

endmodule

/* tests/errt_properties.sv */
`include "errt_settings.svh"

module errt_properties (
	input logic clk,
	input logic rstb,
	input logic enable,
	input logic snap,
	input logic mem_we,
	input logic frozen,
	input logic [errt_ctrl_pkg::FILL_BITS-1:0] fill,
	input errt_ctrl_pkg::capture_state_t state
);

	timeunit 1ns;
	timeprecision 100ps;

	import errt_ctrl_pkg::*;

	localparam int DEPTH = 1 << `ERRT_ADDR_BITS;

	// Count of failed assertions.
	int failures = 0;

	// The memory belongs to the debug side until a re-arm.
	no_write_in_done: assert property (@(posedge clk) disable iff (!rstb)
		(state == DONE && !enable) |=> !mem_we)
	else begin
		$error("capture memory written after the capture froze");
		failures++;
	end

	// A snapshot is stored as exactly four frames.
	snap_four_writes: assert property (@(posedge clk) disable iff (!rstb)
		snap |=> mem_we ##1 mem_we ##1 mem_we ##1 mem_we ##1 !mem_we)
	else begin
		$error("snapshot not followed by exactly four frame writes");
		failures++;
	end

	fill_bounded: assert property (@(posedge clk) disable iff (!rstb)
		int'(fill) <= DEPTH)
	else begin
		$error("fill count beyond memory depth");
		failures++;
	end

	// A full memory always leaves the capture frozen.
	frozen_when_full: assert property (@(posedge clk) disable iff (!rstb)
		(int'(fill) == DEPTH) |-> frozen)
	else begin
		$error("memory full but capture not frozen");
		failures++;
	end

endmodule

/* tests/errt_tb.sv */
`include "errt_settings.svh"

module errt_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import errt_frame_pkg::*;
	import errt_ctrl_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam logic [31:0] SEED = 32'h4b62_99d1;
	localparam int DEPTH = 1 << `ERRT_ADDR_BITS;
	localparam int LANES_PER_FRAME = `ERRT_LANES / 3;
	localparam int SAMPLE_BITS = $bits(lane_sample_t);
	// One read past the last chunk checks the zero response.
	localparam int READS_PER_WORD = `ERRT_CHUNKS + 1;
	localparam int CAPTURE_CYCLES = 8;
	// Upper bounds over all tests, used to size the watchdog.
	localparam int TRIGGER_COUNT = 40;
	localparam int WORDS_READ = 240;
	localparam int TEST_CYCLES = TRIGGER_COUNT * (CAPTURE_CYCLES + 4)
		+ WORDS_READ * READS_PER_WORD + 100;
	localparam int TIMEOUT_NS = TEST_CYCLES * CLK_PERIOD + 400;

	typedef logic [3:0][`ERRT_FRAME_BITS-1:0] word_set_t;

	logic clk;
	logic rstb;
	logic trigger;
	lane_sample_t lanes;
	dbg_req_t dbg;
	dbg_rsp_t rsp;

	logic [`ERRT_FRAME_BITS-1:0] ref_mem [DEPTH];
	int ref_fill;
	bit ref_frozen;

	// Read request issued this cycle and the value it should return.
	bit check_req;
	logic [DBG_DATA_BITS-1:0] check_exp;
	int check_addr;
	int check_chunk;
	bit pend_valid;
	logic [DBG_DATA_BITS-1:0] pend_exp;
	int pend_addr;
	int pend_chunk;

	int checks;
	int data_errors;
	int status_errors;
	int other_errors;

	errt_top dut0 (
		.clk(clk),
		.rstb(rstb),
		.trigger(trigger),
		.lanes(lanes),
		.dbg(dbg),
		.rsp(rsp)
	);

	bind error_tracker errt_properties props0 (
		.clk(clk),
		.rstb(rstb),
		.enable(enable),
		.snap(snap),
		.mem_we(mem_we),
		.frozen(frozen),
		.fill(fill),
		.state(state)
	);

	// Expected memory words of one capture, in frame order.
	function automatic word_set_t expected_words(input lane_sample_t s);
		word_set_t w;
		w = '0;
		for (int f = 0; f < 3; f++) begin
			for (int i = 0; i < LANES_PER_FRAME; i++) begin
				w[f][`ERRT_ERR_BITS * i +: `ERRT_ERR_BITS] = s.err[LANES_PER_FRAME * f + i];
			end
		end
		w[3][`ERRT_LANES-1:0] = s.prbs;
		w[3][2*`ERRT_LANES-1:`ERRT_LANES] = s.data;
		for (int i = 0; i < `ERRT_SD_COUNT; i++) begin
			w[3][2*`ERRT_LANES + 2*i +: 2] = s.sd[`ERRT_SD_FIRST + i];
		end
		return w;
	endfunction

	// Chunk k of a word; the last one is left aligned, later ones read zero.
	function automatic logic [DBG_DATA_BITS-1:0] expected_chunk(
		input logic [`ERRT_FRAME_BITS-1:0] word, input int k);
		if (k < 4) begin
			return word[32*k +: 32];
		end else if (k == 4) begin
			return {word[143:128], 16'h0000};
		end
		return '0;
	endfunction

	function automatic lane_sample_t random_lanes();
		logic [SAMPLE_BITS-1:0] bits;
		for (int i = 0; i < SAMPLE_BITS / 32; i++) begin
			bits[32*i +: 32] = $urandom;
		end
		return bits;
	endfunction

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog expired after %0d ns, run did not complete", TIMEOUT_NS);
		$display("Test failures found");
		$finish;
	end

	always @(posedge clk) begin
		pend_valid <= check_req;
		pend_exp <= check_exp;
		pend_addr <= check_addr;
		pend_chunk <= check_chunk;
	end

	// Read data comes back one cycle after the request is sampled.
	always @(negedge clk) begin
		if (pend_valid) begin
			checks++;
			if (rsp.data !== pend_exp) begin
				$display("mismatch at %0t: rsp.data addr %0d chunk %0d expected %h got %h",
					$time, pend_addr, pend_chunk, pend_exp, rsp.data);
				data_errors++;
			end
		end
	end

	task automatic idle(input int n);
		repeat (n) begin
			lanes = random_lanes();
			@(negedge clk);
		end
	endtask

	task automatic check_status(input bit exp_frozen, input int exp_fill);
		checks++;
		if (rsp.frozen !== exp_frozen) begin
			$display("mismatch at %0t: rsp.frozen expected %0b got %0b",
				$time, exp_frozen, rsp.frozen);
			status_errors++;
		end
		if (rsp.fill !== FILL_BITS'(exp_fill)) begin
			$display("mismatch at %0t: rsp.fill expected %0d got %0d",
				$time, exp_fill, rsp.fill);
			status_errors++;
		end
	endtask

	// Noisy captures keep pulsing trigger with fresh lanes while the frames are stored.
	task automatic capture_once(input bit noisy);
		lane_sample_t s;
		word_set_t w;
		int n;
		s = random_lanes();
		lanes = s;
		trigger = 1'b1;
		@(negedge clk);
		trigger = 1'b0;
		lanes = random_lanes();
		if (ref_frozen) begin
			return;
		end
		w = expected_words(s);
		for (int f = 0; f < 4; f++) begin
			ref_mem[ref_fill + f] = w[f];
		end
		ref_fill += 4;
		if (ref_fill == DEPTH) begin
			ref_frozen = 1'b1;
		end
		n = 0;
		while (int'(rsp.fill) != ref_fill && n < CAPTURE_CYCLES) begin
			if (noisy) begin
				trigger = 1'b1;
				lanes = random_lanes();
			end
			@(negedge clk);
			n++;
		end
		trigger = 1'b0;
		if (int'(rsp.fill) != ref_fill) begin
			$display("capture did not finish at %0t, fill stuck at %0d", $time, rsp.fill);
			other_errors++;
		end
	endtask

	task automatic freeze_capture();
		int n;
		dbg.read = 1'b1;
		n = 0;
		@(negedge clk);
		while (!rsp.frozen && n < CAPTURE_CYCLES) begin
			@(negedge clk);
			n++;
		end
		dbg.read = 1'b0;
		if (!rsp.frozen) begin
			$display("read request at %0t did not freeze the capture", $time);
			other_errors++;
		end
		ref_frozen = 1'b1;
	endtask

	task automatic rearm();
		dbg.enable = 1'b1;
		@(negedge clk);
		dbg.enable = 1'b0;
		ref_fill = 0;
		ref_frozen = 1'b0;
		check_status(1'b0, 0);
	endtask

	task automatic read_back(input int words);
		for (int a = 0; a < words; a++) begin
			for (int c = 0; c < READS_PER_WORD; c++) begin
				dbg.addr = `ERRT_ADDR_BITS'(a);
				dbg.chunk = CHUNK_BITS'(c);
				check_req = 1'b1;
				check_exp = expected_chunk(ref_mem[a], c);
				check_addr = a;
				check_chunk = c;
				@(negedge clk);
			end
		end
		check_req = 1'b0;
	endtask

	initial begin
		int captures;
		int total;
		void'($urandom(SEED));
		rstb = 1'b0;
		trigger = 1'b0;
		lanes = '0;
		dbg = '0;
		check_req = 1'b0;
		check_exp = '0;
		check_addr = 0;
		check_chunk = 0;
		ref_fill = 0;
		ref_frozen = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rstb = 1'b1;
		check_status(1'b0, 0);

		// Random captures with gaps, then freeze and read everything back.
		captures = 3 + int'($urandom_range(3, 0));
		for (int i = 0; i < captures; i++) begin
			capture_once(1'b0);
			idle(int'($urandom_range(2, 0)));
		end
		freeze_capture();
		check_status(1'b1, 4 * captures);
		read_back(4 * captures);

		// Triggers during STORE must be dropped.
		rearm();
		for (int i = 0; i < 3; i++) begin
			capture_once(1'b1);
		end
		freeze_capture();
		check_status(1'b1, 12);
		read_back(12);

		// Seventeen back-to-back captures, the last one finds the memory full.
		rearm();
		for (int i = 0; i < 17; i++) begin
			capture_once(1'b0);
		end
		check_status(1'b1, DEPTH);
		read_back(DEPTH);

		// While frozen, triggers and lane changes leave the memory alone.
		for (int i = 0; i < 5; i++) begin
			capture_once(1'b0);
			idle(1);
		end
		check_status(1'b1, DEPTH);
		read_back(DEPTH);

		// New captures overwrite from address 0, the rest keeps old data.
		rearm();
		capture_once(1'b0);
		capture_once(1'b0);
		freeze_capture();
		check_status(1'b1, 8);
		read_back(DEPTH);

		// Reset while the frames of a capture are being stored.
		rearm();
		lanes = random_lanes();
		trigger = 1'b1;
		@(negedge clk);
		trigger = 1'b0;
		@(negedge clk);
		rstb = 1'b0;
		@(negedge clk);
		check_status(1'b0, 0);
		repeat (3) @(negedge clk);
		rstb = 1'b1;
		@(negedge clk);
		check_status(1'b0, 0);
		ref_fill = 0;
		ref_frozen = 1'b0;
		capture_once(1'b0);
		freeze_capture();
		check_status(1'b1, 4);
		read_back(4);
		idle(2);

		total = data_errors + status_errors + other_errors + dut0.tracker0.props0.failures;
		$display("checks %0d, data errors %0d, status errors %0d, other errors %0d, %s %0d",
			checks, data_errors, status_errors, other_errors, "assertion failures",
			dut0.tracker0.props0.failures);
		if (total == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

/* sources.f */
+incdir+include
rtl/errt_frame_pkg.sv
rtl/errt_ctrl_pkg.sv
rtl/frame_packer.sv
rtl/error_tracker.sv
rtl/capture_sram.sv
rtl/debug_readout.sv
rtl/errt_top.sv
tests/errt_properties.sv
tests/errt_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the error-capture testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
	--top-module errt_tb -Mdir obj_dir -o errt_sim -f sources.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/errt_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qxF 'All tests passed!'; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1
